/* all.f */
+incdir+include
rtl/ex_pkg.sv
rtl/ex_op_if.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_result.sv
rtl/ex_stage.sv
tests/tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# build and run the ex_stage testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -j 0 --top-module tb_ex_stage -f all.f -o tb_ex_stage &&
./obj_dir/tb_ex_stage ||
{ echo "simulation failed"; exit 1; }

/* tests/tb_ex_stage.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

module tb_ex_stage;

    typedef struct packed {
        logic [31:0]         inst;
        logic [`EX_XLEN-1:0] op1;
        logic [`EX_XLEN-1:0] op2;
        logic [`EX_XLEN-1:0] base;
        logic [`EX_XLEN-1:0] off;
        int                  due; // edge after which the result shows
    } stim_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]   rd_wdata;
        logic [`EX_REG_AW-1:0] rd_waddr;
        logic                  reg_wen;
        logic [`EX_XLEN-1:0]   jump_addr;
        logic                  jump_en;
        logic                  mem_wen;
        logic [`EX_XLEN-1:0]   mem_waddr;
        logic [`EX_XLEN-1:0]   mem_wdata;
        logic [`EX_MASK_W-1:0] mem_wmask;
    } out_t;

    logic                  clk;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [31:0]           inst_i;
    logic [`EX_XLEN-1:0]   op1_i;
    logic [`EX_XLEN-1:0]   op2_i;
    logic [`EX_XLEN-1:0]   base_addr_i;
    logic [`EX_XLEN-1:0]   offset_addr_i;
    logic [`EX_XLEN-1:0]   rd_wdata_o;
    logic [`EX_REG_AW-1:0] rd_waddr_o;
    logic                  reg_wen_o;
    logic [`EX_XLEN-1:0]   jump_addr_o;
    logic                  jump_en_o;
    logic                  mem_wen_o;
    logic [`EX_XLEN-1:0]   mem_waddr_o;
    logic [`EX_XLEN-1:0]   mem_wdata_o;
    logic [`EX_MASK_W-1:0] mem_wmask_o;

    integer seed;
    int     edge_cnt;
    int     n_sent;
    int     n_checked;
    stim_t  exp_q[$];
    stim_t  cur;
    out_t   want;

    ex_stage uut (.*);

    always #2 clk = ~clk; // 4 ns period

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // random rs fields and rd around the fields under test
    function automatic logic [31:0] mk_inst(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] word_inst(input int idx);
        case (idx)
            0:       return mk_inst(7'($random(seed)), 3'd0, 7'h1b); // addiw
            1:       return mk_inst(7'h00, 3'd0, 7'h3b); // addw
            2:       return mk_inst(7'h20, 3'd0, 7'h3b); // subw
            3:       return mk_inst(7'h00, 3'd1, 7'h3b); // sllw
            4:       return mk_inst(7'h00, 3'd5, 7'h3b); // srlw
            5:       return mk_inst(7'h20, 3'd5, 7'h3b); // sraw
            default: return mk_inst(7'h20, 3'd5, 7'h1b); // sraiw
        endcase
    endfunction

    function automatic logic [6:0] pick_opc(input int k);
        case (k)
            0:       return 7'h13;
            1:       return 7'h33;
            2:       return 7'h1b;
            3:       return 7'h3b;
            4:       return 7'h63;
            5:       return 7'h23;
            6:       return 7'h6f;
            7:       return 7'h67;
            8:       return 7'h37;
            default: return 7'h17;
        endcase
    endfunction

    // expected outputs straight from the instruction rules
    function automatic out_t ex_ref(input logic [31:0] inst, input logic [63:0] a,
                                    input logic [63:0] b, input logic [63:0] base,
                                    input logic [63:0] off);
        out_t             o;
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic             alt;
        logic             tk;
        logic [63:0]      v;
        logic [31:0]      w;
        ex_pkg::kind_e    k;
        ex_pkg::st_size_e sz;
        o   = '0;
        opc = inst[6:0];
        f3  = inst[14:12];
        alt = inst[30];
        k   = ex_pkg::NONE;
        v   = '0;
        w   = '0;
        tk  = 1'b0;
        sz  = ex_pkg::st_size_e'(f3[1:0]);
        case (opc)
            7'h13, 7'h33: begin
                k = ex_pkg::REG;
                case (f3)
                    3'd0: v = (alt && opc == 7'h33) ? a - b : a + b;
                    3'd1: v = a << b[5:0];
                    3'd2: v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    3'd3: v = (a < b) ? 64'd1 : 64'd0;
                    3'd4: v = a ^ b;
                    3'd5: begin
                        if (alt) v = $signed(a) >>> b[5:0];
                        else     v = a >> b[5:0];
                    end
                    3'd6: v = a | b;
                    default: v = a & b;
                endcase
            end
            7'h1b, 7'h3b: begin
                if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5) begin
                    k = ex_pkg::REG;
                    if (f3 == 3'd0)   w = (alt && opc == 7'h3b) ? a[31:0] - b[31:0]
                                                                : a[31:0] + b[31:0];
                    else if (f3 == 3'd1) w = a[31:0] << b[4:0];
                    else if (alt)        w = $signed(a[31:0]) >>> b[4:0];
                    else                 w = a[31:0] >> b[4:0];
                    v = {{32{w[31]}}, w}; // sign-extend bit 31
                end
            end
            7'h63: begin
                k = ex_pkg::BRANCH;
                case (f3)
                    3'd0: tk = (a == b);
                    3'd1: tk = (a != b);
                    3'd4: tk = ($signed(a) < $signed(b));
                    3'd5: tk = ($signed(a) >= $signed(b));
                    3'd6: tk = (a < b);
                    3'd7: tk = (a >= b);
                    default: k = ex_pkg::NONE;
                endcase
            end
            7'h23: if (!f3[2]) k = ex_pkg::STORE;
            7'h6f: begin
                k = ex_pkg::JUMP;
                v = a + b;
            end
            7'h67: begin
                if (f3 == 3'd0) k = ex_pkg::JUMP;
                v = a + b;
            end
            7'h37: begin
                k = ex_pkg::REG;
                v = b; // lui
            end
            7'h17: begin
                k = ex_pkg::REG;
                v = a + b; // auipc
            end
            default: k = ex_pkg::NONE;
        endcase
        if (k == ex_pkg::REG || k == ex_pkg::JUMP) begin
            o.rd_wdata = v;
            o.rd_waddr = inst[11:7];
            o.reg_wen  = 1'b1;
        end
        if (k == ex_pkg::JUMP || k == ex_pkg::BRANCH) begin
            o.jump_addr = base + off;
            o.jump_en   = (k == ex_pkg::JUMP) ? 1'b1 : tk;
        end
        if (k == ex_pkg::STORE) begin
            o.mem_wen   = 1'b1;
            o.mem_waddr = base + off;
            case (sz)
                ex_pkg::BYTE: begin
                    o.mem_wdata = {56'd0, b[7:0]};
                    o.mem_wmask = 8'h01;
                end
                ex_pkg::HALF: begin
                    o.mem_wdata = {48'd0, b[15:0]};
                    o.mem_wmask = 8'h03;
                end
                ex_pkg::WORD: begin
                    o.mem_wdata = {32'd0, b[31:0]};
                    o.mem_wmask = 8'h0f;
                end
                default: begin
                    o.mem_wdata = b;
                    o.mem_wmask = 8'hff;
                end
            endcase
        end
        return o;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input out_t e);
        check_val("rd_wdata_o", rd_wdata_o, e.rd_wdata);
        check_val("rd_waddr_o", 64'(rd_waddr_o), 64'(e.rd_waddr));
        check_val("reg_wen_o", 64'(reg_wen_o), 64'(e.reg_wen));
        check_val("jump_addr_o", jump_addr_o, e.jump_addr);
        check_val("jump_en_o", 64'(jump_en_o), 64'(e.jump_en));
        check_val("mem_wen_o", 64'(mem_wen_o), 64'(e.mem_wen));
        check_val("mem_waddr_o", mem_waddr_o, e.mem_waddr);
        check_val("mem_wdata_o", mem_wdata_o, e.mem_wdata);
        check_val("mem_wmask_o", 64'(mem_wmask_o), 64'(e.mem_wmask));
    endtask

    task automatic send(input logic [31:0] inst, input logic [63:0] a, input logic [63:0] b,
                        input logic [63:0] base, input logic [63:0] off);
        stim_t s;
        @(negedge clk);
        inst_valid_i  = 1'b1;
        inst_i        = inst;
        op1_i         = a;
        op2_i         = b;
        base_addr_i   = base;
        offset_addr_i = off;
        s.inst = inst;
        s.op1  = a;
        s.op2  = b;
        s.base = base;
        s.off  = off;
        s.due  = edge_cnt + 2; // sampled at the next edge, registered one later
        exp_q.push_back(s);
        n_sent = n_sent + 1;
    endtask

    // junk on the inputs while valid is low
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_valid_i  = 1'b0;
            inst_i        = $random(seed);
            op1_i         = rand64();
            op2_i         = rand64();
            base_addr_i   = rand64();
            offset_addr_i = rand64();
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        idle(1);
        while (exp_q.size() != 0) begin
            if (t >= 50) begin
                $display("timeout: expected results did not come out of the stage");
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
            @(posedge clk);
            t = t + 1;
        end
    endtask

    // compare 1 ns after each rising edge
    always begin
        @(posedge clk);
        edge_cnt = edge_cnt + 1;
        #1;
        if (exp_q.size() != 0 && exp_q[0].due < edge_cnt) begin
            $display("an expected result was never checked, at time %0t", $time);
            $display("RESULT: FAIL");
            $fatal(1, "missed result");
        end
        if (exp_q.size() != 0 && exp_q[0].due == edge_cnt) begin
            cur       = exp_q.pop_front();
            want      = ex_ref(cur.inst, cur.op1, cur.op2, cur.base, cur.off);
            n_checked = n_checked + 1;
        end else begin
            want = '0; // nothing due, all quiet
        end
        check_outputs(want);
    end

    initial begin
        int          i;
        int          j;
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] r;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        op1_i         = '0;
        op2_i         = '0;
        base_addr_i   = '0;
        offset_addr_i = '0;
        seed          = 11331;
        edge_cnt      = 0;
        n_sent        = 0;
        n_checked     = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        idle(8);

        for (i = 0; i < 80; i++) begin
            r = $random(seed);
            a = rand64();
            b = (i % 4 == 3) ? a : rand64();
            if (i % 2 == 0) send(mk_inst(7'($random(seed)), r[2:0], 7'h13), a, b, rand64(), 0);
            else            send(mk_inst(r[3] ? 7'h20 : 7'h00, r[2:0], 7'h33), a, b, 0, 0);
        end

        for (i = 0; i < 7; i++) begin
            for (j = 0; j < 6; j++) begin
                a = rand64();
                b = rand64();
                if (j % 2 == 0) a[31] = 1'b1; // negative low word
                if (j == 1) b[31] = 1'b1;
                send(word_inst(i), a, b, rand64(), rand64());
            end
        end
        send(mk_inst(7'h00, 3'd4, 7'h3b), rand64(), rand64(), 0, 0); // no word xor

        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 5; j++) begin
                case (j)
                    0: begin
                        a = rand64();
                        b = a;
                    end
                    1: begin
                        a = 64'd5;
                        b = 64'd9;
                    end
                    2: begin
                        a = 64'd9;
                        b = 64'd5;
                    end
                    3: begin
                        a = '1;
                        b = 64'd1;
                    end
                    default: begin
                        a = 64'd1;
                        b = '1;
                    end
                endcase
                send(mk_inst(7'($random(seed)), 3'(i < 2 ? i : i + 2), 7'h63),
                     a, b, rand64(), rand64());
            end
        end
        send(mk_inst(7'($random(seed)), 3'($random(seed)), 7'h6f), rand64(), 64'd4, rand64(),
             rand64());
        send(mk_inst(7'($random(seed)), 3'd0, 7'h67), rand64(), 64'd4, rand64(), rand64());
        send(mk_inst(7'($random(seed)), 3'($random(seed)), 7'h37), rand64(), rand64(), 0, 0);
        send(mk_inst(7'($random(seed)), 3'($random(seed)), 7'h17), rand64(), rand64(), 0, 0);

        for (i = 0; i < 8; i++)
            send(mk_inst(7'($random(seed)), 3'(i % 4), 7'h23), rand64(), rand64(), rand64(),
                 rand64());
        send(mk_inst(7'h00, 3'd3, 7'h03), rand64(), rand64(), rand64(), rand64()); // load
        send(mk_inst(7'h7f, 3'd7, 7'h7f), rand64(), rand64(), rand64(), rand64());
        send(mk_inst(7'h00, 3'd5, 7'h23), rand64(), rand64(), rand64(), rand64());
        send(mk_inst(7'h00, 3'd2, 7'h63), 64'd3, 64'd3, rand64(), rand64());
        send(mk_inst(7'h00, 3'd1, 7'h67), rand64(), rand64(), rand64(), rand64());
        idle(3);

        // mixed burst, one strobe per cycle
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            send(mk_inst(r[4] ? 7'h20 : 7'h00, r[7:5], pick_opc(int'({$random(seed)} % 10))),
                 rand64(), rand64(), rand64(), rand64());
        end
        drain();
        idle(4);

        if (n_checked != n_sent) begin
            $display("%0d instructions sent but %0d results checked", n_sent, n_checked);
            $display("RESULT: FAIL");
            $fatal(1, "result count");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic [31:0]           inst_i,
    input  logic [`EX_XLEN-1:0]   op1_i,
    input  logic [`EX_XLEN-1:0]   op2_i,
    input  logic [`EX_XLEN-1:0]   base_addr_i,   // pc or rs1
    input  logic [`EX_XLEN-1:0]   offset_addr_i,
    output logic [`EX_XLEN-1:0]   rd_wdata_o,
    output logic [`EX_REG_AW-1:0] rd_waddr_o,
    output logic                  reg_wen_o,
    output logic [`EX_XLEN-1:0]   jump_addr_o,
    output logic                  jump_en_o,
    output logic                  mem_wen_o,
    output logic [`EX_XLEN-1:0]   mem_waddr_o,
    output logic [`EX_XLEN-1:0]   mem_wdata_o,
    output logic [`EX_MASK_W-1:0] mem_wmask_o
);

    ex_op_if dec_op (); // decode register to alu
    ex_op_if exe_op (); // alu to result register
    logic    taken;

    ex_decode u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .op            (dec_op.producer)
    );

    ex_alu u_alu (
        .in_op   (dec_op.consumer),
        .out_op  (exe_op.producer),
        .taken_o (taken)
    );

    ex_result u_result (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .res         (exe_op.consumer),
        .taken_i     (taken),
        .rd_wdata_o  (rd_wdata_o),
        .rd_waddr_o  (rd_waddr_o),
        .reg_wen_o   (reg_wen_o),
        .jump_addr_o (jump_addr_o),
        .jump_en_o   (jump_en_o),
        .mem_wen_o   (mem_wen_o),
        .mem_waddr_o (mem_waddr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wmask_o (mem_wmask_o)
    );

endmodule

/* rtl/ex_result.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_result (
    input  logic                  clk,
    input  logic                  rst_n_i,
    ex_op_if.consumer             res,
    input  logic                  taken_i,
    output logic [`EX_XLEN-1:0]   rd_wdata_o,
    output logic [`EX_REG_AW-1:0] rd_waddr_o,
    output logic                  reg_wen_o,
    output logic [`EX_XLEN-1:0]   jump_addr_o,
    output logic                  jump_en_o,
    output logic                  mem_wen_o,
    output logic [`EX_XLEN-1:0]   mem_waddr_o,
    output logic [`EX_XLEN-1:0]   mem_wdata_o,
    output logic [`EX_MASK_W-1:0] mem_wmask_o
);

    logic [`EX_XLEN-1:0]   st_data;
    logic [`EX_MASK_W-1:0] st_mask;

    // zero-extend the store data to its size
    always_comb begin
        case (res.st_size)
            ex_pkg::BYTE: begin
                st_data = {{(`EX_XLEN-8){1'b0}}, res.op2[7:0]};
                st_mask = `EX_MASK_W'(1);
            end
            ex_pkg::HALF: begin
                st_data = {{(`EX_XLEN-16){1'b0}}, res.op2[15:0]};
                st_mask = `EX_MASK_W'(3);
            end
            ex_pkg::WORD: begin
                st_data = {{(`EX_XLEN-32){1'b0}}, res.op2[31:0]};
                st_mask = `EX_MASK_W'(15);
            end
            default: begin
                st_data = res.op2; // double
                st_mask = `EX_MASK_W'(255);
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_wdata_o  <= '0;
            rd_waddr_o  <= '0;
            reg_wen_o   <= 1'b0;
            jump_addr_o <= '0;
            jump_en_o   <= 1'b0;
            mem_wen_o   <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            mem_wmask_o <= '0;
        end else begin
            // all fields fall back to zero unless the kind uses them
            rd_wdata_o  <= '0;
            rd_waddr_o  <= '0;
            reg_wen_o   <= 1'b0;
            jump_addr_o <= '0;
            jump_en_o   <= 1'b0;
            mem_wen_o   <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            mem_wmask_o <= '0;
            if (res.valid) begin
                case (res.kind)
                    ex_pkg::REG: begin
                        rd_wdata_o <= res.op1;
                        rd_waddr_o <= res.rd;
                        reg_wen_o  <= 1'b1;
                    end
                    ex_pkg::JUMP: begin
                        rd_wdata_o  <= res.op1; // link value
                        rd_waddr_o  <= res.rd;
                        reg_wen_o   <= 1'b1;
                        jump_addr_o <= res.base;
                        jump_en_o   <= 1'b1;
                    end
                    ex_pkg::BRANCH: begin
                        jump_addr_o <= res.base; // shown even when not taken
                        jump_en_o   <= taken_i;
                    end
                    ex_pkg::STORE: begin
                        mem_wen_o   <= 1'b1;
                        mem_waddr_o <= res.base;
                        mem_wdata_o <= st_data;
                        mem_wmask_o <= st_mask;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_store_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_wen_o |-> !reg_wen_o && !jump_en_o);

    a_rst_quiet: assert property (@(posedge clk)
        !rst_n_i |-> !reg_wen_o && !jump_en_o && !mem_wen_o);

endmodule

/* rtl/ex_alu.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_alu (
    ex_op_if.consumer in_op,
    ex_op_if.producer out_op,
    output logic      taken_o
);

    localparam int SH_W  = $clog2(`EX_XLEN);
    localparam int SH_WW = $clog2(`EX_WLEN);

    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_WLEN-1:0] a_w;
    logic [`EX_WLEN-1:0] b_w;
    logic [SH_W-1:0]     sh;
    logic [SH_WW-1:0]    sh_w;
    logic [`EX_XLEN-1:0] res_x;
    logic [`EX_WLEN-1:0] res_w;
    logic                eq;
    logic                lt_s;
    logic                lt_u;

    assign a    = in_op.op1;
    assign b    = in_op.op2;
    assign a_w  = a[`EX_WLEN-1:0];
    assign b_w  = b[`EX_WLEN-1:0];
    assign sh   = b[SH_W-1:0];   // 6 bits for 64-bit shifts
    assign sh_w = b[SH_WW-1:0];  // 5 bits for word shifts

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (in_op.alu_op)
            ex_pkg::ADD:    res_x = a + b;
            ex_pkg::SUB:    res_x = a - b;
            ex_pkg::SLL:    res_x = a << sh;
            ex_pkg::SLT:    res_x = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ex_pkg::SLTU:   res_x = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ex_pkg::XOR:    res_x = a ^ b;
            ex_pkg::SRL:    res_x = a >> sh;
            ex_pkg::SRA:    res_x = $signed(a) >>> sh;
            ex_pkg::OR:     res_x = a | b;
            ex_pkg::AND:    res_x = a & b;
            ex_pkg::PASS_B: res_x = b;
            default:        res_x = '0;
        endcase
    end

    // word forms work on the low half only
    always_comb begin
        case (in_op.alu_op)
            ex_pkg::ADD: res_w = a_w + b_w;
            ex_pkg::SUB: res_w = a_w - b_w;
            ex_pkg::SLL: res_w = a_w << sh_w;
            ex_pkg::SRL: res_w = a_w >> sh_w;
            ex_pkg::SRA: res_w = $signed(a_w) >>> sh_w;
            default:     res_w = res_x[`EX_WLEN-1:0];
        endcase
    end

    always_comb begin
        case (in_op.br_cond)
            ex_pkg::EQ:  taken_o = eq;
            ex_pkg::NE:  taken_o = !eq;
            ex_pkg::LT:  taken_o = lt_s;
            ex_pkg::GE:  taken_o = !lt_s;
            ex_pkg::LTU: taken_o = lt_u;
            ex_pkg::GEU: taken_o = !lt_u;
            default:     taken_o = 1'b0;
        endcase
    end

    assign out_op.valid   = in_op.valid;
    assign out_op.kind    = in_op.kind;
    assign out_op.alu_op  = in_op.alu_op;
    assign out_op.word    = in_op.word;
    assign out_op.br_cond = in_op.br_cond;
    assign out_op.st_size = in_op.st_size;
    assign out_op.rd      = in_op.rd;

    // sign-extend from bit 31 for word forms
    assign out_op.op1    = in_op.word ? {{(`EX_XLEN-`EX_WLEN){res_w[`EX_WLEN-1]}}, res_w}
                                      : res_x;
    assign out_op.op2    = b;                          // store data
    assign out_op.base   = in_op.base + in_op.offset;  // branch/jump target, store address
    assign out_op.offset = '0;

endmodule

/* rtl/ex_decode.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_decode (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  logic [31:0]         inst_i,
    input  logic [`EX_XLEN-1:0] op1_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    input  logic [`EX_XLEN-1:0] base_addr_i,
    input  logic [`EX_XLEN-1:0] offset_addr_i,
    ex_op_if.producer           op
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`EX_REG_AW-1:0] rd;

    ex_pkg::kind_e         kind_d;
    ex_pkg::alu_op_e       alu_d;
    logic                  word_d;
    ex_pkg::br_cond_e      br_d;
    ex_pkg::st_size_e      st_d;
    logic [`EX_REG_AW-1:0] rd_d;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // funct7[5] picks sra, and sub only for register forms
    function automatic ex_pkg::alu_op_e alu_map(input logic [2:0] f3, input logic alt,
                                                input logic sub_ok);
        ex_pkg::alu_op_e res;
        res = ex_pkg::ADD;
        case (f3)
            `EX_F3_ADD: begin
                if (alt && sub_ok) res = ex_pkg::SUB;
                else               res = ex_pkg::ADD;
            end
            `EX_F3_SLL:  res = ex_pkg::SLL;
            `EX_F3_SLT:  res = ex_pkg::SLT;
            `EX_F3_SLTU: res = ex_pkg::SLTU;
            `EX_F3_XOR:  res = ex_pkg::XOR;
            `EX_F3_SR: begin
                if (alt) res = ex_pkg::SRA;
                else     res = ex_pkg::SRL;
            end
            `EX_F3_OR:   res = ex_pkg::OR;
            `EX_F3_AND:  res = ex_pkg::AND;
        endcase
        return res;
    endfunction

    always_comb begin
        kind_d = ex_pkg::NONE;
        alu_d  = ex_pkg::ADD;
        word_d = 1'b0;
        br_d   = ex_pkg::EQ;
        st_d   = ex_pkg::BYTE;
        case (opcode)
            `EX_OPC_OP_IMM: begin
                kind_d = ex_pkg::REG;
                alu_d  = alu_map(funct3, funct7[5], 1'b0);
            end
            `EX_OPC_OP: begin
                kind_d = ex_pkg::REG;
                alu_d  = alu_map(funct3, funct7[5], 1'b1);
            end
            `EX_OPC_OP_IMM_32, `EX_OPC_OP_32: begin
                word_d = 1'b1;
                // only add/sub and the shifts have word forms
                if (funct3 == `EX_F3_ADD || funct3 == `EX_F3_SLL || funct3 == `EX_F3_SR) begin
                    kind_d = ex_pkg::REG;
                    alu_d  = alu_map(funct3, funct7[5], opcode == `EX_OPC_OP_32);
                end
            end
            `EX_OPC_BRANCH: begin
                kind_d = ex_pkg::BRANCH;
                case (funct3)
                    `EX_F3_BEQ:  br_d = ex_pkg::EQ;
                    `EX_F3_BNE:  br_d = ex_pkg::NE;
                    `EX_F3_BLT:  br_d = ex_pkg::LT;
                    `EX_F3_BGE:  br_d = ex_pkg::GE;
                    `EX_F3_BLTU: br_d = ex_pkg::LTU;
                    `EX_F3_BGEU: br_d = ex_pkg::GEU;
                    default:     kind_d = ex_pkg::NONE; // 010, 011 unused
                endcase
            end
            `EX_OPC_STORE: begin
                kind_d = ex_pkg::STORE;
                case (funct3)
                    `EX_F3_SB: st_d = ex_pkg::BYTE;
                    `EX_F3_SH: st_d = ex_pkg::HALF;
                    `EX_F3_SW: st_d = ex_pkg::WORD;
                    `EX_F3_SD: st_d = ex_pkg::DOUBLE;
                    default:   kind_d = ex_pkg::NONE;
                endcase
            end
            `EX_OPC_JAL:   kind_d = ex_pkg::JUMP; // rd = pc + 4 via add
            `EX_OPC_JALR: begin
                if (funct3 == `EX_F3_JALR) kind_d = ex_pkg::JUMP;
            end
            `EX_OPC_LUI: begin
                kind_d = ex_pkg::REG;
                alu_d  = ex_pkg::PASS_B;
            end
            `EX_OPC_AUIPC: kind_d = ex_pkg::REG; // pc + imm
            default: kind_d = ex_pkg::NONE;
        endcase
    end

    // rd only where a register is written
    assign rd_d = (kind_d == ex_pkg::REG || kind_d == ex_pkg::JUMP) ? rd : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op.valid <= 1'b0;
            op.kind  <= ex_pkg::NONE;
        end else begin
            op.valid <= inst_valid_i; // one-cycle strobe
            if (inst_valid_i) op.kind <= kind_d;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            op.alu_op  <= alu_d;
            op.word    <= word_d;
            op.br_cond <= br_d;
            op.st_size <= st_d;
            op.rd      <= rd_d;
            op.op1     <= op1_i;
            op.op2     <= op2_i;
            op.base    <= base_addr_i;
            op.offset  <= offset_addr_i;
        end
    end

    a_none_no_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
        op.valid && op.kind == ex_pkg::NONE |-> op.rd == '0);

endmodule

/* rtl/ex_op_if.sv */
`timescale 1ns/10ps
`include "ex_cfg.svh"

interface ex_op_if;
    logic                  valid;
    ex_pkg::kind_e         kind;
    ex_pkg::alu_op_e       alu_op;
    logic                  word;    // 32-bit form
    ex_pkg::br_cond_e      br_cond;
    ex_pkg::st_size_e      st_size;
    logic [`EX_REG_AW-1:0] rd;
    logic [`EX_XLEN-1:0]   op1;     // alu result on the execute side
    logic [`EX_XLEN-1:0]   op2;     // store data on the execute side
    logic [`EX_XLEN-1:0]   base;    // target/address on the execute side
    logic [`EX_XLEN-1:0]   offset;

    modport producer (
        output valid, kind, alu_op, word, br_cond, st_size, rd,
        output op1, op2, base, offset
    );

    modport consumer (
        input valid, kind, alu_op, word, br_cond, st_size, rd,
        input op1, op2, base, offset
    );
endinterface

/* rtl/ex_pkg.sv */
package ex_pkg;

    // operation performed by the alu
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10 // lui
    } alu_op_e;

    // what the result stage does with the op
    typedef enum logic [2:0] {
        NONE   = 3'd0, // no side effect
        REG    = 3'd1,
        BRANCH = 3'd2,
        JUMP   = 3'd3, // jal and jalr
        STORE  = 3'd4
    } kind_e;

    typedef enum logic [2:0] {
        EQ  = 3'd0,
        NE  = 3'd1,
        LT  = 3'd2,
        GE  = 3'd3,
        LTU = 3'd4,
        GEU = 3'd5
    } br_cond_e;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } st_size_e;

endpackage

/* include/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

`define EX_XLEN   64 // data and address width
`define EX_WLEN   32 // word forms
`define EX_MASK_W 8  // one bit per byte lane
`define EX_REG_AW 5

// major opcodes
`define EX_OPC_OP_IMM    7'b0010011
`define EX_OPC_OP_IMM_32 7'b0011011
`define EX_OPC_OP        7'b0110011
`define EX_OPC_OP_32     7'b0111011
`define EX_OPC_BRANCH    7'b1100011
`define EX_OPC_STORE     7'b0100011
`define EX_OPC_JAL       7'b1101111
`define EX_OPC_JALR      7'b1100111
`define EX_OPC_LUI       7'b0110111
`define EX_OPC_AUIPC     7'b0010111

// alu funct3
`define EX_F3_ADD  3'b000 // add/sub
`define EX_F3_SLL  3'b001
`define EX_F3_SLT  3'b010
`define EX_F3_SLTU 3'b011
`define EX_F3_XOR  3'b100
`define EX_F3_SR   3'b101 // srl/sra
`define EX_F3_OR   3'b110
`define EX_F3_AND  3'b111

// branch funct3
`define EX_F3_BEQ  3'b000
`define EX_F3_BNE  3'b001
`define EX_F3_BLT  3'b100
`define EX_F3_BGE  3'b101
`define EX_F3_BLTU 3'b110
`define EX_F3_BGEU 3'b111

// store funct3
`define EX_F3_SB   3'b000
`define EX_F3_SH   3'b001
`define EX_F3_SW   3'b010
`define EX_F3_SD   3'b011

`define EX_F3_JALR 3'b000

`endif
